// ==== logic/dac_macros.svh ====
/*
 * DAC serial link constants
 * Frame length, serial clock timing and word queue depth
 */

`ifndef DAC_MACROS_SVH
`define DAC_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// Frame format
//////////////////////////////////////////////////////////////////////

// Bits per SPI frame, MSB first
// Receiver bit counter wraps to all ones, so keep a power of two
`define DAC_FRAME_BITS 16

//////////////////////////////////////////////////////////////////////
// Serial clock
//////////////////////////////////////////////////////////////////////

// mclk cycles per half sclk period
// Frame length in mclk is 18 * 2 * DAC_SCLK_HALF
`define DAC_SCLK_HALF 2

//////////////////////////////////////////////////////////////////////
// Host side queue
//////////////////////////////////////////////////////////////////////

`define DAC_FIFO_DEPTH 4 // Words held ahead of the frame master

`endif

// ==== logic/dac_pkg.sv ====
/*
 * DAC link types
 * Power-down field, frame master states and the DAC word layout
 */

package dac_pkg;

  //////////////////////////////////////////////////////////////////////
  // DAC121S101 power-down field (bits 13:12 of the frame)
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    PD_NORMAL   = 2'b00, // Output driving
    PD_1K_GND   = 2'b01, // Output to ground through 1k
    PD_100K_GND = 2'b10, // Output to ground through 100k
    PD_HIGH_Z   = 2'b11  // Output floating
  } pd_mode_e;

  //////////////////////////////////////////////////////////////////////
  // Frame master sequencing
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    FR_IDLE  = 2'd0, // Waiting for a queued word
    FR_SHIFT = 2'd1, // sync_n low, data bits going out
    FR_TRAIL = 2'd2, // sync_n high, closing falling edge
    FR_GAP   = 2'd3  // Quiet period before next frame
  } frame_state_e;

  // One DAC word, laid out in frame order (MSB sent first)
  typedef struct packed {
    logic [1:0] rsvd; // Don't care in the DAC, kept zero
    pd_mode_e   pd;   // Power-down mode
    logic [11:0] code; // Output code
  } dac_word_t;

endpackage

// ==== logic/dac_word_fifo.sv ====
/*
 * DAC word queue
 * Small circular buffer between the host write strobe and the frame master
 */

`timescale 1ns/1ps

`include "dac_macros.svh"

module dac_word_fifo (
  input  logic              mclk,
  input  logic              arst_n,
  input  logic              wr,      // Host write strobe
  input  dac_pkg::dac_word_t wr_word, // Word to queue
  input  logic              pop,     // Frame master takes head
  output dac_pkg::dac_word_t head,    // Oldest word
  output logic              empty,
  output logic              full
);

  // Pointer and count widths
  localparam int AW = (`DAC_FIFO_DEPTH > 1) ? $clog2(`DAC_FIFO_DEPTH) : 1;
  localparam int CW = $clog2(`DAC_FIFO_DEPTH + 1);
  localparam logic [AW-1:0] LAST_IDX = AW'(`DAC_FIFO_DEPTH - 1);
  localparam logic [CW-1:0] FULL_CNT = CW'(`DAC_FIFO_DEPTH);

  dac_pkg::dac_word_t mem [`DAC_FIFO_DEPTH]; // Word storage

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count; // Occupancy
  logic          push_ok;
  logic          pop_ok;

  //////////////////////////////////////////////////////////////////////
  // Status
  //////////////////////////////////////////////////////////////////////

  assign empty   = (count == '0);
  assign full    = (count == FULL_CNT);
  assign push_ok = wr & ~full;  // Writes while full are dropped
  assign pop_ok  = pop & ~empty; // Guard, master never pops empty

  assign head = mem[rd_ptr]; // Visible the edge after the push

  //////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge mclk) begin
    if (push_ok) begin
      mem[wr_ptr] <= wr_word;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Pointers and occupancy
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge mclk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + 1'b1; // Wrap
      end
      if (pop_ok) begin
        rd_ptr <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + 1'b1; // Wrap
      end
      case ({push_ok, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // Both or neither
      endcase
    end
  end

endmodule

// ==== logic/spi_frame_master.sv ====
/*
 * SPI frame master for a DAC121S101-style converter
 * Divides mclk into sclk, frames one queued word per sync_n low period
 * and shifts it out MSB first, with an abort that cuts the frame short
 */

`timescale 1ns/1ps

`include "dac_macros.svh"

module spi_frame_master (
  input  logic              mclk,
  input  logic              arst_n,
  input  logic              empty,  // Queue status
  input  dac_pkg::dac_word_t head,   // Next word to send
  input  logic              abort,  // Host abort pulse
  output logic              pop,    // Take head from queue
  output logic              busy,   // Frame in progress
  output logic              sclk,   // Serial clock, idles high
  output logic              sync_n, // Frame sync, low active
  output logic              din     // Serial data
);

  localparam int FB = `DAC_FRAME_BITS;
  localparam int HW = $clog2(`DAC_SCLK_HALF + 1);
  localparam int BW = $clog2(FB);
  localparam logic [HW-1:0] HALF_LAST = HW'(`DAC_SCLK_HALF - 1);
  localparam logic [BW-1:0] BIT_LAST  = BW'(FB - 1);

  dac_pkg::frame_state_e state;

  logic [HW-1:0] half_cnt; // mclk cycles in current half period
  logic          phase;    // 0 first half (sclk high), 1 second half
  logic [BW-1:0] bit_cnt;  // sclk periods done in FR_SHIFT
  logic [FB-1:0] shift_q;  // Output shifter
  logic          half_end;
  logic          period_end;
  logic          abort_hit;

  //////////////////////////////////////////////////////////////////////
  // Control decode
  //////////////////////////////////////////////////////////////////////

  assign pop        = (state == dac_pkg::FR_IDLE) & ~empty; // Start a frame
  assign abort_hit  = abort & (state == dac_pkg::FR_SHIFT);  // Ignored elsewhere
  assign half_end   = (half_cnt == HALF_LAST);
  assign period_end = half_end & phase; // Rising sclk edge
  assign busy       = (state != dac_pkg::FR_IDLE);
  assign din        = shift_q[FB-1]; // MSB first

  //////////////////////////////////////////////////////////////////////
  // sclk timing
  //////////////////////////////////////////////////////////////////////

  // Half period counter, restarted on frame start and abort
  always_ff @(posedge mclk or negedge arst_n) begin
    if (!arst_n) begin
      half_cnt <= '0;
      phase    <= 1'b0;
    end else if (state == dac_pkg::FR_IDLE || abort_hit) begin
      half_cnt <= '0;
      phase    <= 1'b0;
    end else if (half_end) begin
      half_cnt <= '0;
      phase    <= ~phase;
    end else begin
      half_cnt <= half_cnt + 1'b1;
    end
  end

  // Toggles only in FR_SHIFT and FR_TRAIL, stays high in the gap
  always_ff @(posedge mclk or negedge arst_n) begin
    if (!arst_n) begin
      sclk <= 1'b1;
    end else if (abort_hit) begin
      sclk <= 1'b1; // Trail period restarts from the high half
    end else if (half_end && (state == dac_pkg::FR_SHIFT ||
                              state == dac_pkg::FR_TRAIL)) begin
      sclk <= phase; // Falls after first half, rises after second
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Frame FSM and shifter
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge mclk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= dac_pkg::FR_IDLE;
      sync_n  <= 1'b1;
      bit_cnt <= '0;
      shift_q <= '0; // Keeps din low out of reset
    end else begin
      case (state)
        dac_pkg::FR_IDLE: begin
          if (pop) begin
            state   <= dac_pkg::FR_SHIFT;
            sync_n  <= 1'b0;
            bit_cnt <= '0;
            shift_q <= head; // First bit valid before first falling edge
          end
        end
        dac_pkg::FR_SHIFT: begin
          // Abort after the 16th falling edge is too late, word already in DAC
          if (abort) begin
            state  <= dac_pkg::FR_TRAIL;
            sync_n <= 1'b1;
          end else if (period_end) begin
            if (bit_cnt == BIT_LAST) begin
              state  <= dac_pkg::FR_TRAIL; // All bits out
              sync_n <= 1'b1;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
              shift_q <= {shift_q[FB-2:0], 1'b0}; // Next bit on rising sclk
            end
          end
        end
        dac_pkg::FR_TRAIL: begin
          if (period_end) begin
            state <= dac_pkg::FR_GAP; // Closing falling edge has passed
          end
        end
        dac_pkg::FR_GAP: begin
          if (period_end) begin
            state <= dac_pkg::FR_IDLE;
          end
        end
        default: state <= dac_pkg::FR_IDLE;
      endcase
    end
  end

endmodule

// ==== logic/dac_serial_receiver.sv ====
/*
 * DAC121S101-style serial input register
 * Shifts din on falling sclk and latches code and power-down mode
 * when sync_n rises after a complete frame
 */

`timescale 1ns/1ps

`include "dac_macros.svh"

module dac_serial_receiver (
  input  logic              sclk,    // Serial clock, sampled on falling edge
  input  logic              arst_n,
  input  logic              sync_n,  // Frame sync, low active
  input  logic              din,     // Serial data
  output logic [11:0]       vout,    // Latched output code
  output dac_pkg::pd_mode_e pd_mode  // Latched power-down mode
);

  localparam int FB = `DAC_FRAME_BITS;
  localparam int CW = $clog2(FB);
  localparam logic [CW-1:0] CNT_START = CW'(FB - 2); // First bit already in

  logic          sync_dly_n; // sync_n at previous falling edge
  logic [CW-1:0] bit_cnt;
  logic          cnt_done;   // All ones once every bit has arrived
  logic          frm_start;
  logic          frm_done;
  logic [FB-1:0] shifter;
  dac_pkg::dac_word_t rx_word;

  //////////////////////////////////////////////////////////////////////
  // Frame start and bit count
  //////////////////////////////////////////////////////////////////////

  always_ff @(negedge sclk or negedge arst_n) begin
    if (!arst_n) sync_dly_n <= 1'b1;
    else         sync_dly_n <= sync_n;
  end

  assign frm_start = ~sync_n & sync_dly_n; // First falling edge of frame
  assign cnt_done  = (bit_cnt == '1);

  // Counts down from start, sticks at all ones
  always_ff @(negedge sclk or negedge arst_n) begin
    if (!arst_n) begin
      bit_cnt <= '1;
    end else if (sync_n) begin
      bit_cnt <= '1;
    end else if (frm_start) begin
      bit_cnt <= CNT_START;
    end else if (!cnt_done) begin
      bit_cnt <= bit_cnt - 1'b1;
    end
  end

  // sync_n just went high with every bit in, short frames fall through
  assign frm_done = sync_n & ~sync_dly_n & cnt_done;

  //////////////////////////////////////////////////////////////////////
  // Data path
  //////////////////////////////////////////////////////////////////////

  always_ff @(negedge sclk) begin
    shifter <= {shifter[FB-2:0], din}; // MSB first
  end

  assign rx_word = shifter;

  always_ff @(negedge sclk or negedge arst_n) begin
    if (!arst_n) begin
      vout    <= '0;
      pd_mode <= dac_pkg::PD_NORMAL;
    end else if (frm_done) begin
      vout    <= rx_word.code;
      pd_mode <= rx_word.pd;
    end
  end

endmodule

// ==== logic/dac_spi_top.sv ====
/*
 * DAC serial link top level
 * Host word queue, SPI frame master and DAC receiver model
 */

`timescale 1ns/1ps

module dac_spi_top (
  input  logic              mclk,
  input  logic              arst_n,
  input  logic              wr,      // Host write strobe
  input  dac_pkg::dac_word_t wr_word, // Host DAC word
  input  logic              abort,   // Cut the current frame short
  output logic              full,    // Queue full, writes dropped
  output logic              busy,    // Frame in progress
  output logic              sclk,
  output logic              sync_n,
  output logic              din,
  output logic [11:0]       vout,    // DAC code
  output dac_pkg::pd_mode_e pd_mode  // DAC power-down mode
);

  // Queue to master
  dac_pkg::dac_word_t head;
  logic               empty;
  logic               pop;

  //////////////////////////////////////////////////////////////////////
  // Host side
  //////////////////////////////////////////////////////////////////////

  dac_word_fifo u_fifo (
    .mclk    (mclk),
    .arst_n  (arst_n),
    .wr      (wr),
    .wr_word (wr_word),
    .pop     (pop),
    .head    (head),
    .empty   (empty),
    .full    (full)
  );

  spi_frame_master u_master (
    .mclk   (mclk),
    .arst_n (arst_n),
    .empty  (empty),
    .head   (head),
    .abort  (abort),
    .pop    (pop),
    .busy   (busy),
    .sclk   (sclk),
    .sync_n (sync_n),
    .din    (din)
  );

  //////////////////////////////////////////////////////////////////////
  // Converter side
  //////////////////////////////////////////////////////////////////////

  dac_serial_receiver u_dac (
    .sclk    (sclk),
    .arst_n  (arst_n),
    .sync_n  (sync_n),
    .din     (din),
    .vout    (vout),
    .pd_mode (pd_mode)
  );

endmodule

// ==== bench/dac_spi_sva.sv ====
/*
 * Frame signalling checks for the DAC SPI link
 * Bound into the top level, watches master state, sync and queue pops
 */

`timescale 1ns/1ps

module dac_spi_sva (
  input logic                  mclk,
  input logic                  arst_n,
  input logic                  wr,
  input logic                  full,
  input logic                  busy,
  input logic                  sync_n,
  input logic                  sclk,
  input logic                  din,
  input logic                  pop,
  input dac_pkg::frame_state_e state
);

  // One sticky flag per check
  logic quiet_bad = 1'b0;
  logic idle_bad  = 1'b0;
  logic pop_bad   = 1'b0;
  logic din_bad   = 1'b0;
  logic any_fail;
  int   occ; // Words accepted from the host and not yet popped

  assign any_fail = quiet_bad | idle_bad | pop_bad | din_bad;

  // Occupancy seen from the host writes and the master pops
  always_ff @(posedge mclk or negedge arst_n) begin
    if (!arst_n) begin
      occ <= 0;
    end else begin
      occ <= occ + int'(wr && !full) - int'(pop);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Frame signalling
  //////////////////////////////////////////////////////////////////////

  sync_high_when_idle: assert property (
    @(posedge mclk) disable iff (!arst_n) !busy |-> sync_n
  ) else begin
    quiet_bad = 1'b1;
    $error("sync_n low while no frame is in progress");
  end

  sclk_high_in_idle: assert property (
    @(posedge mclk) disable iff (!arst_n) (state == dac_pkg::FR_IDLE) |-> sclk
  ) else begin
    idle_bad = 1'b1;
    $error("sclk low in FR_IDLE");
  end

  no_pop_when_empty: assert property (
    @(posedge mclk) disable iff (!arst_n) pop |-> (occ != 0)
  ) else begin
    pop_bad = 1'b1;
    $error("Queue popped while empty");
  end

  // Frame start loads din with sclk high, so only mid-frame high halves
  din_stable_sclk_high: assert property (
    @(posedge mclk) disable iff (!arst_n)
      (sclk && $past(sclk) && !sync_n && !$past(sync_n)) |-> $stable(din)
  ) else begin
    din_bad = 1'b1;
    $error("din changed while sclk was high");
  end

endmodule

bind dac_spi_top dac_spi_sva u_sva (
  .mclk   (mclk),
  .arst_n (arst_n),
  .wr     (wr),
  .full   (full),
  .busy   (busy),
  .sync_n (sync_n),
  .sclk   (sclk),
  .din    (din),
  .pop    (pop),
  .state  (u_master.state)
);

// ==== bench/dac_spi_tb.sv ====
/*
 * DAC SPI link testbench
 * Seeded random DAC words through queue, frame master and receiver,
 * checked against a word-level model of the link
 */

`timescale 1ns/1ps

`include "dac_macros.svh"

module dac_spi_tb;

  localparam int BURST_LEN   = `DAC_FIFO_DEPTH + 4; // Overruns the queue
  localparam int MAX_WORDS   = 1 + BURST_LEN + 4 + 3;
  localparam int FRAME_MCLK  = 18 * 2 * `DAC_SCLK_HALF;
  localparam int CYCLE_LIMIT = 2 * MAX_WORDS * FRAME_MCLK + 200;
  // Longest abort wait that still lands before the last falling sclk
  localparam int ABORT_MAX   = `DAC_SCLK_HALF * (2 * `DAC_FRAME_BITS - 1) - 1;

  logic               mclk;
  logic               arst_n;
  logic               wr;
  dac_pkg::dac_word_t wr_word;
  logic               abort;
  logic               full;
  logic               busy;
  logic               sclk;
  logic               sync_n;
  logic               din;
  logic [11:0]        vout;
  dac_pkg::pd_mode_e  pd_mode;

  //////////////////////////////////////////////////////////////////////
  // Link model
  //////////////////////////////////////////////////////////////////////

  dac_pkg::dac_word_t exp_q [$]; // Accepted, not yet framed
  dac_pkg::dac_word_t cur_word;  // Word of the frame in flight
  logic               cur_aborted;
  logic               in_frame;
  logic [11:0]        exp_vout;  // Last committed word
  dac_pkg::pd_mode_e  exp_pd;
  int                 frames;    // sync_n falling edges
  int                 frame_t0;  // mclk count at frame start
  logic               sync_prev;
  logic               busy_prev;

  int errors;
  int tests_passed;
  int tests_failed;
  int cycles = 0;

  dac_spi_top uut (
    .mclk    (mclk),
    .arst_n  (arst_n),
    .wr      (wr),
    .wr_word (wr_word),
    .abort   (abort),
    .full    (full),
    .busy    (busy),
    .sclk    (sclk),
    .sync_n  (sync_n),
    .din     (din),
    .vout    (vout),
    .pd_mode (pd_mode)
  );

  initial begin
    mclk = 1'b0;
    forever #10 mclk = ~mclk; // 20 ns period
  end

  always @(posedge mclk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout after %0d mclk cycles with frames still pending", cycles);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // Frame start pops the model queue, frame end commits unless aborted
  function automatic void observe();
    if (!arst_n) begin
      sync_prev = 1'b1;
      busy_prev = 1'b0;
    end else begin
      if (sync_prev && !sync_n) begin
        frames++;
        frame_t0 = cycles;
        assert (exp_q.size() != 0) else begin
          $display("Frame started with no accepted word left in the model");
          errors++;
        end
        if (exp_q.size() != 0) cur_word = exp_q.pop_front();
        cur_aborted = 1'b0;
        in_frame    = 1'b1;
      end
      if (busy_prev && !busy) begin
        if (!cur_aborted) begin
          exp_vout = cur_word.code;
          exp_pd   = cur_word.pd;
          // Full frame is 18 sclk periods of busy
          assert (cycles - frame_t0 == FRAME_MCLK) else begin
            $display("Fail frame busy cycles got %h expected %h",
                     cycles - frame_t0, FRAME_MCLK);
            errors++;
          end
        end
        in_frame = 1'b0;
      end
      sync_prev = sync_n;
      busy_prev = busy;
    end
  endfunction

  function automatic dac_pkg::dac_word_t make_word(dac_pkg::pd_mode_e pd, logic [11:0] code);
    dac_pkg::dac_word_t w;
    w.rsvd = 2'b00;
    w.pd   = pd;
    w.code = code;
    return w;
  endfunction

  function automatic dac_pkg::pd_mode_e random_pd();
    return dac_pkg::pd_mode_e'(2'($urandom_range(3, 0)));
  endfunction

  function automatic logic [11:0] random_code();
    return 12'($urandom());
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Drive and check helpers, all on the falling mclk edge
  //////////////////////////////////////////////////////////////////////

  task automatic tick();
    @(negedge mclk);
    observe(); // Outputs settled since the rising edge
  endtask

  task automatic send_word(input dac_pkg::dac_word_t w, output logic taken);
    tick();
    taken   = !full; // Pushed at next edge only if not full
    wr      = 1'b1;
    wr_word = w;
    if (taken) exp_q.push_back(w);
  endtask

  task automatic stop_write();
    tick();
    wr = 1'b0;
  endtask

  task automatic wait_idle();
    while (busy || in_frame || exp_q.size() != 0) tick();
  endtask

  task automatic check_outputs(input string tag);
    assert (vout === exp_vout) else begin
      $display("Fail %s vout got %h expected %h", tag, vout, exp_vout);
      errors++;
    end
    assert (pd_mode === exp_pd) else begin
      $display("Fail %s pd_mode got %h expected %h", tag, pd_mode, exp_pd);
      errors++;
    end
  endtask

  task automatic write_and_check(input dac_pkg::dac_word_t w, input string tag);
    logic taken;
    send_word(w, taken);
    stop_write();
    wait_idle();
    assert (taken) else begin
      $display("Word %s was refused although the queue was idle", tag);
      errors++;
    end
    check_outputs(tag);
  endtask

  task automatic end_test(input string name, input int err0);
    if (errors == err0) begin
      tests_passed++;
      $display("Test %s passed", name);
    end else begin
      tests_failed++;
      $display("Test %s failed", name);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    dac_pkg::dac_word_t w;
    dac_pkg::dac_word_t last;
    logic taken;
    int   err0;
    int   frames0;
    int   accepted;
    int   dropped;
    int   k;
    arst_n = 1'b1;
    wr = 1'b0;
    wr_word = '0;
    abort = 1'b0;
    cur_word = '0;
    cur_aborted = 1'b0;
    in_frame = 1'b0;
    exp_vout = '0;
    exp_pd = dac_pkg::PD_NORMAL;
    frames = 0;
    frame_t0 = 0;
    errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    void'($urandom(53335));
    #1 arst_n = 1'b0;
    repeat (5) tick();
    arst_n = 1'b1;

    err0 = errors; // Reset values
    repeat (2) tick();
    check_outputs("reset");
    assert (full === 1'b0 && busy === 1'b0) else begin
      $display("Fail reset full got %h busy got %h expected 0", full, busy);
      errors++;
    end
    end_test("reset", err0);

    err0 = errors;
    write_and_check(make_word(dac_pkg::PD_NORMAL, random_code()), "single");
    end_test("single", err0);

    err0 = errors; // Burst past the queue depth
    frames0 = frames;
    accepted = 0;
    dropped = 0;
    last = '0;
    for (int i = 0; i < BURST_LEN; i++) begin
      w = make_word(random_pd(), random_code());
      send_word(w, taken);
      if (taken) begin
        accepted++;
        last = w;
      end else begin
        dropped++;
      end
    end
    stop_write();
    wait_idle();
    assert (dropped > 0) else begin
      $display("Burst never filled the queue so no write was dropped");
      errors++;
    end
    assert (frames - frames0 == accepted) else begin
      $display("Fail burst sync_n frames got %h expected %h", frames - frames0, accepted);
      errors++;
    end
    assert (vout === last.code) else begin
      $display("Fail burst vout got %h expected %h", vout, last.code);
      errors++;
    end
    assert (pd_mode === last.pd) else begin
      $display("Fail burst pd_mode got %h expected %h", pd_mode, last.pd);
      errors++;
    end
    check_outputs("burst");
    end_test("burst", err0);

    err0 = errors; // Every power-down mode
    for (int m = 0; m < 4; m++) begin
      write_and_check(make_word(dac_pkg::pd_mode_e'(2'(m)), random_code()), "pd_modes");
    end
    end_test("pd_modes", err0);

    err0 = errors; // Commit, abort, commit
    last = make_word(random_pd(), random_code());
    write_and_check(last, "abort_first");
    send_word(make_word(random_pd(), ~last.code), taken);
    stop_write();
    while (sync_n !== 1'b0) tick(); // First falling mclk in the frame
    k = $urandom_range(ABORT_MAX, 0);
    repeat (k) tick();
    abort = 1'b1;
    cur_aborted = 1'b1;
    tick();
    abort = 1'b0;
    wait_idle();
    check_outputs("aborted");
    write_and_check(make_word(random_pd(), random_code()), "after_abort");
    end_test("abort", err0);

    assert (!uut.u_sva.any_fail) else begin
      $display("A bound concurrent assertion on the frame signals failed");
      errors++;
    end
    $display("Tests passed %0d failed %0d, check errors %0d",
             tests_passed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+logic
logic/dac_pkg.sv
logic/dac_word_fifo.sv
logic/spi_frame_master.sv
logic/dac_serial_receiver.sv
logic/dac_spi_top.sv
bench/dac_spi_sva.sv
bench/dac_spi_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the DAC SPI link testbench with Verilator, run it, grep the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f sources.f --top-module dac_spi_tb \
  -Mdir obj_dir -o dac_spi_sim || { echo "Verilator build failed"; exit 1; }

./obj_dir/dac_spi_sim +verilator+error+limit+100 > sim.log 2>&1 \
  || echo "Simulator exited with an error status"
cat sim.log

grep -qx "=== PASS ===" sim.log && { echo "Simulation passed"; exit 0; } \
  || { echo "Simulation failed"; exit 1; }
